// File: common/siggen_macros.svh
`ifndef SIGGEN_MACROS_SVH
`define SIGGEN_MACROS_SVH

`define FRAME_BITS      120

// frame lengths in bits
`define LEN_QUERY       16
`define LEN_ENABLE      40
`define LEN_PWM         96
`define LEN_DDS         112

`define CMD_GET_ID      8'd0
`define CMD_GET_CONFIG  8'd1
`define CMD_GET_RESULT  8'd4

`define GROUP_OUTPUT    8'd3
`define OP_SET          8'd2
`define OP_ENABLE       8'd5

`define ID_DDS          8'h1
`define ID_PWM          8'h4
`define ID_FC           8'h2
`define ID_NONE         8'h0

`define DDS_TYPE        16'd6        // ad9959 compatible
`define MCLK_HZ         32'd250000000
`define MAX_MV          16'd3300
`define PWM_CHANNELS    8'd4
`define PWM_BITS        8'd32
`define FC_CHANNELS     8'd2
`define FC_RESOLUTION   8'd4

`define FC_GATE_CYCLES  200          // clk cycles per window

`endif

// File: common/siggen_pkg.sv
`include "siggen_macros.svh"

package siggen_pkg;

    typedef logic [`FRAME_BITS-1:0] frame_t;

    typedef logic [7:0] bit_count_t;

    // dds code, pwm period or duty
    typedef logic [31:0] code_t;

    typedef logic [1:0] channel_t;

    typedef logic [31:0] count_t;

    typedef enum logic [1:0] {
        dec_idle,
        dec_exec,
        dec_clear_wait
    } dec_state_t;

endpackage

// File: spi/spi_slave.sv
`timescale 1ns/10ps

module spi_slave import siggen_pkg::*; (
    input  logic       clk,
    input  logic       nreset,
    input  logic       sck,
    input  logic       mosi,
    input  logic       ncs,
    output logic       miso,
    output frame_t     frame,
    output bit_count_t bit_count,
    output logic       frame_done,
    input  frame_t     reply,
    input  logic       reply_load
);

    logic [1:0] sck_sync;
    logic [1:0] ncs_sync;
    logic [1:0] mosi_sync;
    logic       sck_prev;
    logic       ncs_prev;
    logic       sck_rise;
    logic       sck_fall;
    logic       ncs_rise;
    logic       ncs_fall;
    frame_t     reply_sr;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            sck_sync  <= 2'b00;
            ncs_sync  <= 2'b11;
            mosi_sync <= 2'b00;
            sck_prev  <= 1'b0;
            ncs_prev  <= 1'b1;
        end else begin
            sck_sync  <= {sck_sync[0], sck};
            ncs_sync  <= {ncs_sync[0], ncs};
            mosi_sync <= {mosi_sync[0], mosi};
            sck_prev  <= sck_sync[1];
            ncs_prev  <= ncs_sync[1];
        end
    end

    assign sck_rise = sck_sync[1] & ~sck_prev;
    assign sck_fall = ~sck_sync[1] & sck_prev;
    assign ncs_rise = ncs_sync[1] & ~ncs_prev;
    assign ncs_fall = ~ncs_sync[1] & ncs_prev;

    always_ff @(posedge clk) begin
        if (sck_rise && !ncs_sync[1])
            frame <= {frame[$bits(frame_t)-2:0], mosi_sync[1]}; // msb first
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            bit_count  <= '0;
            frame_done <= 1'b0;
            reply_sr   <= '0;
        end else begin
            frame_done <= ncs_rise && (bit_count != '0);
            if (ncs_fall)
                bit_count <= '0;
            else if (sck_rise && !ncs_sync[1])
                bit_count <= bit_count + 1'b1;
            if (reply_load)
                reply_sr <= reply;
            else if (sck_fall && !ncs_sync[1])
                reply_sr <= {reply_sr[$bits(frame_t)-2:0], 1'b0};
        end
    end

    assign miso = ncs ? 1'b0 : reply_sr[$bits(frame_t)-1]; // quiet while deselected

endmodule

// File: logic/command_decoder.sv
`timescale 1ns/10ps
`include "siggen_macros.svh"

module command_decoder import siggen_pkg::*; (
    input  logic       clk,
    input  logic       nreset,
    input  frame_t     frame,
    input  bit_count_t bit_count,
    input  logic       frame_done,
    output frame_t     reply,
    output logic       reply_load,
    output code_t      dds_code [4],
    output code_t      pwm_period [4],
    output code_t      pwm_duty [4],
    input  count_t     fc_result0,
    input  count_t     fc_result1,
    input  logic       fc_ready0,
    input  logic       fc_ready1,
    output logic       ready_clear
);

    dec_state_t state;
    frame_t     cmd;
    bit_count_t len;
    frame_t     next_reply;
    logic [3:0] dds_en;
    logic [3:0] pwm_en;
    code_t      dds_bak [4];
    code_t      period_q [4];
    code_t      duty_bak [4];
    logic       interrupt;

    // byte idx of a frame of len bits, idx 0 sent first
    function automatic logic [7:0] byte_of(frame_t f, int flen, int idx);
        return f[flen-1-8*idx -: 8];
    endfunction

    // swap so the lsb byte goes out first
    function automatic logic [31:0] le32(logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic logic [15:0] le16(logic [15:0] w);
        return {w[7:0], w[15:8]};
    endfunction

    assign interrupt = fc_ready0 & fc_ready1;

    always_comb begin
        next_reply = '0;
        if (len == `LEN_QUERY) begin
            case (byte_of(cmd, `LEN_QUERY, 0))
                `CMD_GET_ID:
                    next_reply[`FRAME_BITS-1 -: 32] = {`ID_DDS, `ID_PWM, `ID_FC, `ID_NONE};
                `CMD_GET_CONFIG: begin
                    case (byte_of(cmd, `LEN_QUERY, 1)) // subdevice
                        8'd0: next_reply[`FRAME_BITS-1 -: 64] =
                            {le16(`DDS_TYPE), le32(`MCLK_HZ), le16(`MAX_MV)};
                        8'd1: next_reply[`FRAME_BITS-1 -: 48] =
                            {le32(`MCLK_HZ), `PWM_CHANNELS, `PWM_BITS};
                        8'd2: next_reply[`FRAME_BITS-1 -: 16] = {`FC_CHANNELS, `FC_RESOLUTION};
                        default: next_reply = '0;
                    endcase
                end
                `CMD_GET_RESULT:
                    next_reply[`FRAME_BITS-1 -: 64] = {le32(fc_result0), le32(fc_result1)};
                default: next_reply = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == dec_idle && frame_done) begin
            cmd <= frame;
            len <= bit_count;
        end
        if (state == dec_exec)
            reply <= next_reply;
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            state       <= dec_idle;
            reply_load  <= 1'b0;
            ready_clear <= 1'b0;
            dds_en      <= '0;
            pwm_en      <= '0;
            for (int i = 0; i < 4; i++) begin
                dds_bak[i]  <= '0;
                period_q[i] <= code_t'(1);
                duty_bak[i] <= '0;
            end
        end else begin
            reply_load <= 1'b0;
            case (state)
                dec_idle: begin
                    if (frame_done)
                        state <= dec_exec;
                end
                dec_exec: begin
                    reply_load <= 1'b1;
                    state      <= dec_idle;
                    case (len)
                        `LEN_QUERY: begin
                            if (byte_of(cmd, `LEN_QUERY, 0) == `CMD_GET_RESULT) begin
                                ready_clear <= 1'b1;
                                state       <= dec_clear_wait;
                            end
                        end
                        `LEN_ENABLE: begin
                            if (byte_of(cmd, `LEN_ENABLE, 1) == `GROUP_OUTPUT &&
                                byte_of(cmd, `LEN_ENABLE, 2) == `OP_ENABLE) begin
                                case (byte_of(cmd, `LEN_ENABLE, 0)) // target
                                    8'd0: dds_en[channel_t'(byte_of(cmd, `LEN_ENABLE, 3))] <=
                                        byte_of(cmd, `LEN_ENABLE, 4) != 8'd0;
                                    8'd1: pwm_en[channel_t'(byte_of(cmd, `LEN_ENABLE, 3))] <=
                                        byte_of(cmd, `LEN_ENABLE, 4) != 8'd0;
                                    default: ;
                                endcase
                            end
                        end
                        `LEN_PWM: begin
                            if (byte_of(cmd, `LEN_PWM, 1) == `GROUP_OUTPUT &&
                                byte_of(cmd, `LEN_PWM, 2) == `OP_SET) begin
                                period_q[channel_t'(byte_of(cmd, `LEN_PWM, 0))] <=
                                    le32(cmd[63:32]);
                                duty_bak[channel_t'(byte_of(cmd, `LEN_PWM, 0))] <=
                                    le32(cmd[31:0]);
                            end
                        end
                        `LEN_DDS: begin
                            if (byte_of(cmd, `LEN_DDS, 1) == `GROUP_OUTPUT &&
                                byte_of(cmd, `LEN_DDS, 2) == `OP_SET)
                                dds_bak[channel_t'(byte_of(cmd, `LEN_DDS, 0))] <= le32(cmd[31:0]);
                        end
                        default: ; // unknown length, reply only
                    endcase
                end
                dec_clear_wait: begin
                    if (!interrupt) begin
                        ready_clear <= 1'b0;
                        state       <= dec_idle;
                    end
                end
                default: state <= dec_idle;
            endcase
        end
    end

    // disabled channels output zero, backups keep the last write
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            dds_code[i]   = dds_en[i] ? dds_bak[i] : '0;
            pwm_period[i] = period_q[i];
            pwm_duty[i]   = pwm_en[i] ? duty_bak[i] : '0;
        end
    end

endmodule

// File: logic/output_bank.sv
`timescale 1ns/10ps

module output_bank import siggen_pkg::*; (
    input  logic       clk,
    input  logic       nreset,
    input  code_t      dds_code [4],
    input  code_t      pwm_period [4],
    input  code_t      pwm_duty [4],
    output logic [3:0] dds_out,
    output logic [3:0] pwm_out
);

    code_t acc [4];
    code_t pwm_cnt [4];
    code_t act_period [4];
    code_t act_duty [4];

    // phase accumulators
    always_ff @(posedge clk) begin
        if (!nreset) begin
            for (int i = 0; i < 4; i++)
                acc[i] <= '0;
        end else begin
            for (int i = 0; i < 4; i++)
                acc[i] <= acc[i] + dds_code[i];
        end
    end

    // pwm counters, new period and duty picked up at the wrap
    always_ff @(posedge clk) begin
        if (!nreset) begin
            for (int i = 0; i < 4; i++) begin
                pwm_cnt[i]    <= '0;
                act_period[i] <= code_t'(1);
                act_duty[i]   <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (pwm_cnt[i] + 1'b1 >= act_period[i]) begin // also covers period 0
                    pwm_cnt[i]    <= '0;
                    act_period[i] <= pwm_period[i];
                    act_duty[i]   <= pwm_duty[i];
                end else begin
                    pwm_cnt[i] <= pwm_cnt[i] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            dds_out[i] = acc[i][31];
            pwm_out[i] = pwm_cnt[i] < act_duty[i];
        end
    end

endmodule

// File: logic/frequency_counter.sv
`timescale 1ns/10ps
`include "siggen_macros.svh"

module frequency_counter import siggen_pkg::*; (
    input  logic   clk,
    input  logic   nreset,
    input  logic   sig_in,
    input  logic   ready_clear,
    output count_t result,
    output logic   ready
);

    localparam int GATE_W = $clog2(`FC_GATE_CYCLES);

    logic [1:0]        sig_sync;
    logic              sig_prev;
    logic              sig_rise;
    logic [GATE_W-1:0] gate_cnt;
    count_t            edge_cnt;
    logic              gate_end;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            sig_sync <= 2'b00;
            sig_prev <= 1'b0;
        end else begin
            sig_sync <= {sig_sync[0], sig_in};
            sig_prev <= sig_sync[1];
        end
    end

    assign sig_rise = sig_sync[1] & ~sig_prev;
    assign gate_end = gate_cnt == GATE_W'(`FC_GATE_CYCLES - 1);

    always_ff @(posedge clk) begin
        if (!nreset) begin
            gate_cnt <= '0;
            edge_cnt <= '0;
            ready    <= 1'b0;
        end else begin
            if (gate_end) begin
                gate_cnt <= '0;
                edge_cnt <= '0;
            end else begin
                gate_cnt <= gate_cnt + 1'b1;
                edge_cnt <= edge_cnt + count_t'(sig_rise);
            end
            if (ready_clear)
                ready <= 1'b0;
            else if (gate_end)
                ready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (gate_end && !ready_clear)
            result <= edge_cnt + count_t'(sig_rise); // last cycle of the window
    end

endmodule

// File: logic/siggen_top.sv
`timescale 1ns/10ps

module siggen_top import siggen_pkg::*; (
    input  logic       clk,
    input  logic       nreset,
    input  logic       sck,
    input  logic       mosi,
    input  logic       ncs,
    input  logic [1:0] freq_in,
    output logic       miso,
    output logic       interrupt,
    output logic [3:0] dds_out,
    output logic [3:0] pwm_out
);

    frame_t     frame;
    bit_count_t bit_count;
    logic       frame_done;
    frame_t     reply;
    logic       reply_load;
    code_t      dds_code [4];
    code_t      pwm_period [4];
    code_t      pwm_duty [4];
    count_t     fc_result0;
    count_t     fc_result1;
    logic       fc_ready0;
    logic       fc_ready1;
    logic       ready_clear;

    spi_slave u_spi (
        .clk(clk), .nreset(nreset), .sck(sck), .mosi(mosi), .ncs(ncs), .miso(miso),
        .frame(frame), .bit_count(bit_count), .frame_done(frame_done),
        .reply(reply), .reply_load(reply_load)
    );

    command_decoder u_dec (
        .clk(clk), .nreset(nreset), .frame(frame), .bit_count(bit_count),
        .frame_done(frame_done), .reply(reply), .reply_load(reply_load),
        .dds_code(dds_code), .pwm_period(pwm_period), .pwm_duty(pwm_duty),
        .fc_result0(fc_result0), .fc_result1(fc_result1),
        .fc_ready0(fc_ready0), .fc_ready1(fc_ready1), .ready_clear(ready_clear)
    );

    output_bank u_out (
        .clk(clk), .nreset(nreset), .dds_code(dds_code), .pwm_period(pwm_period),
        .pwm_duty(pwm_duty), .dds_out(dds_out), .pwm_out(pwm_out)
    );

    frequency_counter u_fc0 (
        .clk(clk), .nreset(nreset), .sig_in(freq_in[0]), .ready_clear(ready_clear),
        .result(fc_result0), .ready(fc_ready0)
    );

    frequency_counter u_fc1 (
        .clk(clk), .nreset(nreset), .sig_in(freq_in[1]), .ready_clear(ready_clear),
        .result(fc_result1), .ready(fc_ready1)
    );

    assign interrupt = fc_ready0 & fc_ready1; // both results waiting

endmodule

// File: sim/siggen_assertions.sv
`timescale 1ns/10ps

module siggen_assertions (
    input logic       clk,
    input logic       nreset,
    input logic       ncs,
    input logic       miso,
    input logic       interrupt,
    input logic       fc_ready0,
    input logic       fc_ready1,
    input logic [3:0] dds_out,
    input logic [3:0] pwm_out
);

    int   fail_cnt = 0;
    logic rst_seen;

    always_ff @(posedge clk) begin
        rst_seen <= !nreset; // one reset cycle already applied
    end

    assert property (@(posedge clk) ncs |-> !miso)
        else begin
            fail_cnt++;
            $error("miso driven while ncs is high");
        end

    assert property (@(posedge clk) interrupt == (fc_ready0 & fc_ready1))
        else begin
            fail_cnt++;
            $error("interrupt differs from both ready levels");
        end

    assert property (@(posedge clk) (!nreset && rst_seen) |->
        (dds_out == 4'h0 && pwm_out == 4'h0 && !miso && !interrupt))
        else begin
            fail_cnt++;
            $error("outputs not quiet during reset");
        end

endmodule

bind siggen_top siggen_assertions u_assert (
    .clk(clk), .nreset(nreset), .ncs(ncs), .miso(miso), .interrupt(interrupt),
    .fc_ready0(fc_ready0), .fc_ready1(fc_ready1), .dds_out(dds_out), .pwm_out(pwm_out)
);

// File: sim/tb_siggen.sv
`timescale 1ns/10ps

module tb_siggen;

    logic       clk;
    logic       nreset;
    logic       sck;
    logic       mosi;
    logic       ncs;
    logic [1:0] freq_in;
    logic       miso;
    logic       interrupt;
    logic [3:0] dds_out;
    logic [3:0] pwm_out;

    int          half0 = 0;
    int          half1 = 0;
    int          n_lines = 0;
    int          errors = 0;
    int          int_falls = 0;
    logic        int_prev = 1'b0;
    logic [31:0] rng_state = 32'd84;
    string       lines[$];

    siggen_top u_dut (
        .clk(clk), .nreset(nreset), .sck(sck), .mosi(mosi), .ncs(ncs),
        .freq_in(freq_in), .miso(miso), .interrupt(interrupt),
        .dds_out(dds_out), .pwm_out(pwm_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // frequency sources stay low at half period 0
    initial begin
        forever begin
            @(posedge clk);
            if (half0 > 0) begin
                repeat (half0 - 1) @(posedge clk);
                freq_in[0] <= ~freq_in[0];
            end
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            if (half1 > 0) begin
                repeat (half1 - 1) @(posedge clk);
                freq_in[1] <= ~freq_in[1];
            end
        end
    end

    always @(negedge clk) begin
        if (int_prev && !interrupt)
            int_falls++;
        int_prev <= interrupt;
    end

    initial begin
        wait (n_lines > 0);
        #(n_lines * 20000);
        $display("timeout: trace did not finish in time");
        $display("Something failed");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] byte_swap(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input int tol,
                         input string msg);
        logic [63:0] d;
        d = (got > exp) ? got - exp : exp - got;
        if (d > 64'(tol)) begin
            errors++;
            $display("FAILED %0t: %s got %0h expected %0h", $time, msg, got, exp);
        end
    endtask

    // mode 0 host with an sck half period of 4 clk
    task automatic send_frame(input int len, input logic [119:0] v, output logic [119:0] rx);
        for (int k = 3; k <= 9; k++) begin
            if ((len == 96 && k == 3) || (len == 112)) begin
                rng_state = xorshift(rng_state);
                v[len-1-8*k -: 8] = rng_state[7:0]; // pad byte
            end
        end
        rx = '0;
        @(posedge clk) ncs <= 1'b0;
        repeat (4) @(posedge clk);
        for (int i = len - 1; i >= 0; i--) begin
            mosi <= v[i];
            repeat (3) @(posedge clk);
            @(negedge clk) rx = {rx[118:0], miso};
            @(posedge clk) sck <= 1'b1;
            repeat (4) @(posedge clk);
            sck <= 1'b0;
        end
        repeat (4) @(posedge clk);
        ncs  <= 1'b1;
        mosi <= 1'b0;
        repeat (10) @(posedge clk);
    endtask

    function automatic logic out_bit(input bit pwm, input int ch);
        return pwm ? pwm_out[ch] : dds_out[ch];
    endfunction

    task automatic wait_rise(input bit pwm, input int ch, input int maxc, output bit ok);
        logic prev;
        ok = 1'b0;
        @(negedge clk) prev = out_bit(pwm, ch);
        for (int i = 0; i < maxc && !ok; i++) begin
            @(negedge clk);
            ok = !prev && out_bit(pwm, ch);
            prev = out_bit(pwm, ch);
        end
        if (!ok) begin
            errors++;
            $display("no rising edge on channel %0d output within %0d cycles", ch, maxc);
        end
    endtask

    task automatic measure_dds(input int ch, input int n, input int period);
        logic [3:0] first;
        logic       prev;
        logic       rose;
        bit         ok;
        int         cyc;
        if (period == 0) begin
            @(negedge clk) first = dds_out;
            repeat (n) @(negedge clk) check(64'(dds_out), 64'(first), 0, "dds constant");
        end else begin
            wait_rise(1'b0, ch, n, ok);
            cyc = 0;
            if (ok) begin
                prev = 1'b1;
                do begin
                    @(negedge clk) cyc++;
                    rose = !prev && dds_out[ch];
                    prev = dds_out[ch];
                end while (!rose && cyc < n);
                check(64'(cyc), 64'(period), 0, "dds period");
            end
        end
    endtask

    task automatic measure_pwm(input int ch, input int n, input int high);
        logic [3:0] rest;
        logic [3:0] rest0;
        bit         ok;
        int         cnt;
        ok = 1'b1;
        cnt = 0;
        if (high > 0 && high < n)
            wait_rise(1'b1, ch, n, ok);
        else
            @(negedge clk);
        if (ok) begin
            rest0 = pwm_out & ~(4'b0001 << ch);
            for (int i = 0; i < n; i++) begin
                cnt += int'(pwm_out[ch]);
                rest = pwm_out & ~(4'b0001 << ch);
                check(64'(rest), 64'(rest0), 0, "pwm other channels");
                @(negedge clk);
            end
            check(64'(cnt), 64'(high), 0, "pwm high cycles");
        end
    endtask

    initial begin
        int          fd;
        int          n;
        int          a;
        int          b;
        int          c;
        int          t_err;
        int          n_tests;
        int          n_failed;
        bit          ok;
        string       op;
        string       name;
        string       line;
        logic [119:0] fv;
        logic [119:0] rx;
        logic [63:0]  ev;
        logic [63:0]  ev2;

        nreset  = 1'b0;
        sck     = 1'b0;
        mosi    = 1'b0;
        ncs     = 1'b1;
        freq_in = 2'b00;
        name = "";
        n_tests = 0;
        n_failed = 0;
        t_err = 0;
        fd = $fopen("sim/siggen_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the trace file sim/siggen_trace.txt");
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0)
                    lines.push_back(line);
            end
            $fclose(fd);
        end
        n_lines = lines.size() + 1;
        repeat (4) @(posedge clk);
        nreset <= 1'b1;
        repeat (4) @(posedge clk);

        foreach (lines[li]) begin
            n = $sscanf(lines[li], "%s", op);
            if (n < 1 || op == "#")
                continue;
            case (op)
                "T": begin
                    if (name != "") begin
                        n_tests++;
                        n_failed += (errors > t_err) ? 1 : 0;
                        $display("test %s: %s", name, (errors > t_err) ? "failed" : "passed");
                    end
                    t_err = errors;
                    n = $sscanf(lines[li], "%s %s", op, name);
                end
                "X": begin
                    n = $sscanf(lines[li], "%s %d %h %d %h", op, a, fv, b, ev);
                    send_frame(a, fv, rx);
                    if (b > 0)
                        check(64'(rx >> (a - b)), ev, 0, "reply");
                end
                "F": n = $sscanf(lines[li], "%s %d %d", op, half0, half1);
                "C": begin
                    n = $sscanf(lines[li], "%s %d", op, a);
                    repeat (a) @(posedge clk);
                end
                "D": begin
                    n = $sscanf(lines[li], "%s %d %d %d", op, a, b, c);
                    measure_dds(a, b, c);
                end
                "W": begin
                    n = $sscanf(lines[li], "%s %d %d %d", op, a, b, c);
                    measure_pwm(a, b, c);
                end
                "I": begin
                    n = $sscanf(lines[li], "%s %d %d", op, a, b);
                    ok = 1'b0;
                    for (int i = 0; i < b && !ok; i++)
                        @(negedge clk) ok = (interrupt == a[0]);
                    if (!ok) begin
                        errors++;
                        $display("interrupt did not reach level %0d within %0d cycles", a, b);
                    end
                end
                "L": begin
                    n = $sscanf(lines[li], "%s %d", op, a);
                    check(64'(int_falls), 64'(a), 0, "interrupt falls");
                end
                "Q": begin
                    n = $sscanf(lines[li], "%s %d %d", op, ev, ev2);
                    send_frame(64, '0, rx);
                    check(64'(byte_swap(rx[63:32])), ev, 1, "count 0");
                    check(64'(byte_swap(rx[31:0])), ev2, 1, "count 1");
                end
                default: begin
                    errors++;
                    $display("unknown trace operation %s", op);
                end
            endcase
        end
        if (name != "") begin
            n_tests++;
            n_failed += (errors > t_err) ? 1 : 0;
            $display("test %s: %s", name, (errors > t_err) ? "failed" : "passed");
        end
        if (u_dut.u_assert.fail_cnt > 0) begin
            $display("%0d assertion failures during the run", u_dut.u_assert.fail_cnt);
            errors += u_dut.u_assert.fail_cnt;
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 n_tests, n_tests - n_failed, n_failed, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// File: sim/siggen_trace.txt
# op fields: T name | X len frame(hex) reply_bits expected(hex) | F half0 half1 | C cycles
# D ch cycles period | W ch cycles high | I level timeout | L falls | Q count0 count1
T ident_config
X 16 0000 0 0
X 64 0 32 01040200
X 16 0100 0 0
X 64 0 64 060080b2e60ee40c
X 16 0101 0 0
X 64 0 48 80b2e60e0420
X 16 0102 0 0
X 64 0 16 0204
T dds_gating
X 112 0003020000000000000000000040 0 0
D 0 64 0
X 40 0003050001 0 0
D 0 64 4
X 40 0003050000 0 0
D 0 64 0
T pwm
X 96 010302000a00000003000000 0 0
X 40 0103050101 0 0
W 1 100 30
X 96 010302000800000008000000 0 0
C 20
W 1 40 40
T freq_counter
F 5 10
C 500
I 1 1000
X 16 0400 0 0
L 1
Q 20 10
I 1 1000
T robustness
X 112 0004020000000000000000000040 0 0
X 40 0003060001 0 0
X 24 000305 0 0
D 0 64 0
W 1 40 40
X 16 0000 0 0
X 64 0 32 01040200

// File: sim.f
+incdir+common
common/siggen_pkg.sv
spi/spi_slave.sv
logic/command_decoder.sv
logic/output_bank.sv
logic/frequency_counter.sv
logic/siggen_top.sv
sim/siggen_assertions.sv
sim/tb_siggen.sv

// File: run_sim.sh
#!/bin/bash
# build and run the siggen testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_siggen -f sim.f \
    -o Vtb_siggen > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/Vtb_siggen +verilator+error+limit+100 > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "^Everything OK$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
